//--- rtl/dsp_ctrl.sv
// Instruction decoder turning each fetched word into one-cycle control pulses for the address units
`timescale 1ns/1ps

module dsp_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic [dsp_pkg::INSTR_W-1:0]  instr,
    dsp_ctrl_if.ctrl                     bus,
    output logic                         fault
);

    logic [4:0]        t_raw;
    dsp_pkg::t_field_e t_code;
    logic              xfer_load;    // R=Y rather than Y=R
    logic              double_word;  // Next word is long immediate data

    // Fold the T encodings that share a group onto one enum code
    always_comb begin
        t_raw     = instr[15:11];
        xfer_load = (t_raw == dsp_pkg::T_RAM_LOAD);
        // Bit 11 is part of the operand for goto and short immediate
        if (t_raw[4:2] == 3'b000) begin
            t_raw[0] = 1'b0;
        end
        if (xfer_load) begin
            t_raw = dsp_pkg::T_RAM_XFER;
        end
        t_code = dsp_pkg::t_field_e'(t_raw);
    end

    // Control pulses, double-word tracking and fault
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.goto_ja    <= 1'b0;
            bus.short_load <= 1'b0;
            bus.long_load  <= 1'b0;
            bus.ram_load   <= 1'b0;
            bus.ram_we     <= 1'b0;
            double_word    <= 1'b0;
            fault          <= 1'b0;
        end else begin
            // Pulses last one cycle
            bus.goto_ja    <= 1'b0;
            bus.short_load <= 1'b0;
            bus.long_load  <= 1'b0;
            bus.ram_load   <= 1'b0;
            bus.ram_we     <= 1'b0;
            if (instr_valid) begin
                if (double_word) begin
                    bus.long_load <= 1'b1;  // Word is data, not decoded
                    double_word   <= 1'b0;
                end else begin
                    case (t_code)
                        dsp_pkg::T_GOTO_JA:   bus.goto_ja    <= 1'b1;
                        dsp_pkg::T_SHORT_IMM: bus.short_load <= 1'b1;
                        dsp_pkg::T_LONG_IMM:  double_word    <= 1'b1;
                        dsp_pkg::T_RAM_XFER: begin
                            bus.ram_load <= xfer_load;
                            bus.ram_we   <= ~xfer_load;
                        end
                        default: fault <= 1'b1;  // Sticky until reset
                    endcase
                end
            end
        end
    end

    // Instruction fields, captured alongside the pulses
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            if (double_word) begin
                bus.long_imm <= instr;
            end else begin
                bus.i_field   <= instr[11:0];
                bus.short_imm <= instr[8:0];
                bus.ptr_sel   <= instr[3:2];
                bus.post_mod  <= dsp_pkg::post_mod_e'(instr[1:0]);
                if (t_code == dsp_pkg::T_SHORT_IMM) begin
                    bus.r_field <= dsp_pkg::reg_sel_e'(instr[11:9]);
                end else if (t_code == dsp_pkg::T_LONG_IMM ||
                             t_code == dsp_pkg::T_RAM_XFER) begin
                    // Long immediate keeps it across the data word
                    bus.r_field <= dsp_pkg::reg_sel_e'(instr[6:4]);
                end
            end
        end
    end

endmodule

//--- rtl/dsp_ctrl_if.sv
// Decoder control pulses and instruction fields, shared by the decoder and both address units
`timescale 1ns/1ps

interface dsp_ctrl_if;

    // ROM address unit
    logic                            goto_ja;
    logic [dsp_pkg::PC_W-1:0]        i_field;   // Goto target

    // Register loads
    logic                            short_load;
    logic                            long_load;
    logic [dsp_pkg::IMM_SHORT_W-1:0] short_imm;
    logic [dsp_pkg::INSTR_W-1:0]     long_imm;  // Second word of a long immediate

    // RAM transfers
    logic                            ram_load;  // R=Y
    logic                            ram_we;    // Y=R
    dsp_pkg::reg_sel_e               r_field;
    logic [1:0]                      ptr_sel;
    dsp_pkg::post_mod_e              post_mod;

    logic                            data_busy; // Data access in progress

    modport ctrl (
        output goto_ja, i_field, short_load, long_load, short_imm, long_imm,
        output ram_load, ram_we, r_field, ptr_sel, post_mod
    );

    modport xaau (input goto_ja, i_field, data_busy);

    modport yaau (
        input  short_load, long_load, short_imm, long_imm,
        input  ram_load, ram_we, r_field, ptr_sel, post_mod,
        output data_busy
    );

endinterface

//--- rtl/dsp_pkg.sv
// Shared opcode, register and width definitions for the DSP front end, referenced by scoped name

package dsp_pkg;

    // Bus and field widths
    localparam int INSTR_W     = 16;  // Instruction and data word
    localparam int PC_W        = 12;  // Program address
    localparam int IMM_SHORT_W = 9;   // Short immediate, sign-extended on load
    localparam int NUM_REGS    = 5;   // r0 to r3 plus j

    // T field, instruction bits 15:11
    typedef enum logic [4:0] {
        T_GOTO_JA   = 5'b00000,
        T_SHORT_IMM = 5'b00010,
        T_LONG_IMM  = 5'b01010,
        T_RAM_XFER  = 5'b01100   // Y=R store, also the group code for R=Y
    } t_field_e;

    // R=Y load shares the transfer group with Y=R
    localparam logic [4:0] T_RAM_LOAD = 5'b01111;

    // Register targets
    typedef enum logic [2:0] {
        R0 = 3'd0,
        R1 = 3'd1,
        R2 = 3'd2,
        R3 = 3'd3,
        RJ = 3'd4   // Step register, codes 5 to 7 unused
    } reg_sel_e;

    // Pointer post-modify, instruction bits 1:0
    typedef enum logic [1:0] {
        PM_NONE = 2'd0,
        PM_INC  = 2'd1,
        PM_DEC  = 2'd2,
        PM_STEP = 2'd3   // Adds j
    } post_mod_e;

endpackage

//--- rtl/dsp_top.sv
// Top level of the DSP front end joining decoder and both address units to the two Wishbone buses
`timescale 1ns/1ps

module dsp_top (
    input  logic                         clk,
    input  logic                         rst,
    // Instruction bus
    output logic                         iwb_cyc,
    output logic                         iwb_stb,
    output logic [dsp_pkg::PC_W-1:0]     iwb_adr,
    input  logic [dsp_pkg::INSTR_W-1:0]  iwb_dat_i,
    input  logic                         iwb_ack,
    // Data bus
    output logic                         dwb_cyc,
    output logic                         dwb_stb,
    output logic                         dwb_we,
    output logic [dsp_pkg::INSTR_W-1:0]  dwb_adr,
    output logic [dsp_pkg::INSTR_W-1:0]  dwb_dat_o,
    input  logic [dsp_pkg::INSTR_W-1:0]  dwb_dat_i,
    input  logic                         dwb_ack,
    output logic                         fault
);

    logic                        instr_valid;
    logic [dsp_pkg::INSTR_W-1:0] instr;

    dsp_ctrl_if ctrl_bus ();

    dsp_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .bus         (ctrl_bus.ctrl),
        .fault       (fault)
    );

    dsp_xaau u_xaau (
        .clk         (clk),
        .rst         (rst),
        .bus         (ctrl_bus.xaau),
        .instr_valid (instr_valid),
        .instr       (instr),
        .iwb_cyc     (iwb_cyc),
        .iwb_stb     (iwb_stb),
        .iwb_adr     (iwb_adr),
        .iwb_dat_i   (iwb_dat_i),
        .iwb_ack     (iwb_ack)
    );

    dsp_yaau u_yaau (
        .clk         (clk),
        .rst         (rst),
        .bus         (ctrl_bus.yaau),
        .dwb_cyc     (dwb_cyc),
        .dwb_stb     (dwb_stb),
        .dwb_we      (dwb_we),
        .dwb_adr     (dwb_adr),
        .dwb_dat_o   (dwb_dat_o),
        .dwb_dat_i   (dwb_dat_i),
        .dwb_ack     (dwb_ack)
    );

endmodule

//--- rtl/dsp_xaau.sv
// ROM address unit holding the program counter and running the instruction-fetch Wishbone master
`timescale 1ns/1ps

module dsp_xaau (
    input  logic                         clk,
    input  logic                         rst,
    dsp_ctrl_if.xaau                     bus,
    output logic                         instr_valid,
    output logic [dsp_pkg::INSTR_W-1:0]  instr,
    output logic                         iwb_cyc,
    output logic                         iwb_stb,
    output logic [dsp_pkg::PC_W-1:0]     iwb_adr,
    input  logic [dsp_pkg::INSTR_W-1:0]  iwb_dat_i,
    input  logic                         iwb_ack
);

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        WAIT_DATA
    } state_e;

    state_e                   state;
    logic [dsp_pkg::PC_W-1:0] pc;

    assign iwb_stb = iwb_cyc;
    assign iwb_adr = pc;

    // Decoder samples the word on the ack edge
    assign instr_valid = iwb_cyc & iwb_ack;
    assign instr       = iwb_dat_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= FETCH;
            pc      <= '0;
            iwb_cyc <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!iwb_cyc) begin
                        iwb_cyc <= 1'b1;  // First fetch after reset
                    end else if (iwb_ack) begin
                        iwb_cyc <= 1'b0;
                        pc      <= pc + 1'b1;
                        state   <= DECODE;
                    end
                end
                DECODE: begin
                    // Control pulses are live in this cycle
                    if (bus.goto_ja) begin
                        pc <= bus.i_field;
                    end
                    if (bus.data_busy) begin
                        state <= WAIT_DATA;
                    end else begin
                        state   <= FETCH;
                        iwb_cyc <= 1'b1;
                    end
                end
                default: begin  // WAIT_DATA
                    if (!bus.data_busy) begin
                        state   <= FETCH;
                        iwb_cyc <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/dsp_yaau.sv
// RAM address unit with pointer and step registers, post-modify logic and the data Wishbone master
`timescale 1ns/1ps

module dsp_yaau (
    input  logic                         clk,
    input  logic                         rst,
    dsp_ctrl_if.yaau                     bus,
    output logic                         dwb_cyc,
    output logic                         dwb_stb,
    output logic                         dwb_we,
    output logic [dsp_pkg::INSTR_W-1:0]  dwb_adr,
    output logic [dsp_pkg::INSTR_W-1:0]  dwb_dat_o,
    input  logic [dsp_pkg::INSTR_W-1:0]  dwb_dat_i,
    input  logic                         dwb_ack
);

    localparam int EXT_W = dsp_pkg::INSTR_W - dsp_pkg::IMM_SHORT_W;

    logic [dsp_pkg::INSTR_W-1:0] regs [dsp_pkg::NUM_REGS];  // r0 to r3, then j
    logic [dsp_pkg::INSTR_W-1:0] ptr;
    logic [dsp_pkg::INSTR_W-1:0] step;
    logic [dsp_pkg::INSTR_W-1:0] ptr_next;
    logic [dsp_pkg::INSTR_W-1:0] short_ext;
    logic                        dst_ok;    // Register code names a real register
    logic                        xfer_done;

    assign dst_ok    = (bus.r_field <= dsp_pkg::RJ);
    assign short_ext = {{EXT_W{bus.short_imm[dsp_pkg::IMM_SHORT_W-1]}}, bus.short_imm};
    assign ptr       = regs[bus.ptr_sel];
    assign step      = regs[dsp_pkg::RJ];
    assign xfer_done = dwb_cyc & dwb_ack;

    // Busy from the pulse itself, then from the running cycle
    assign bus.data_busy = bus.ram_load | bus.ram_we | dwb_cyc;

    assign dwb_stb   = dwb_cyc;
    assign dwb_adr   = ptr;
    assign dwb_dat_o = dst_ok ? regs[bus.r_field] : '0;

    always_comb begin
        case (bus.post_mod)
            dsp_pkg::PM_INC:  ptr_next = ptr + 1'b1;
            dsp_pkg::PM_DEC:  ptr_next = ptr - 1'b1;
            dsp_pkg::PM_STEP: ptr_next = ptr + step;
            default:          ptr_next = ptr;
        endcase
    end

    // One data-bus cycle per transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwb_cyc <= 1'b0;
            dwb_we  <= 1'b0;
        end else if (bus.ram_load || bus.ram_we) begin
            dwb_cyc <= 1'b1;
            dwb_we  <= bus.ram_we;
        end else if (xfer_done) begin
            dwb_cyc <= 1'b0;
            dwb_we  <= 1'b0;
        end
    end

    // Register file updates
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < dsp_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (bus.short_load && dst_ok) begin
                regs[bus.r_field] <= short_ext;
            end
            if (bus.long_load && dst_ok) begin
                regs[bus.r_field] <= bus.long_imm;
            end
            if (xfer_done) begin
                regs[bus.ptr_sel] <= ptr_next;
                // Loaded word wins over post-modify of the same register
                if (!dwb_we && dst_ok) begin
                    regs[bus.r_field] <= dwb_dat_i;
                end
            end
        end
    end

endmodule

//--- verif/dsp_tb.sv
// Directed testbench for the DSP front end, with program and data memory models on both buses
`timescale 1ns/1ps

module dsp_tb;

    localparam int MAX_CYCLES = 3000;  // About 80 instructions at up to 12 cycles, plus resets

    logic                        clk;
    logic                        rst;
    logic                        iwb_cyc;
    logic                        iwb_stb;
    logic                        iwb_ack;
    logic [dsp_pkg::PC_W-1:0]    iwb_adr;
    logic [dsp_pkg::INSTR_W-1:0] iwb_dat_i;
    logic                        dwb_cyc;
    logic                        dwb_stb;
    logic                        dwb_we;
    logic                        dwb_ack;
    logic                        fault;
    logic [dsp_pkg::INSTR_W-1:0] dwb_adr;
    logic [dsp_pkg::INSTR_W-1:0] dwb_dat_o;
    logic [dsp_pkg::INSTR_W-1:0] dwb_dat_i;

    logic [dsp_pkg::INSTR_W-1:0] pmem [0:(1<<dsp_pkg::PC_W)-1];
    logic [dsp_pkg::INSTR_W-1:0] dmem [0:65535];
    logic [dsp_pkg::INSTR_W-1:0] mregs [0:4];     // Model of r0 to r3 and j
    logic [dsp_pkg::PC_W-1:0]    fetch_q[$];
    logic [dsp_pkg::PC_W-1:0]    exp_fetch[$];
    logic [dsp_pkg::INSTR_W-1:0] wr_adr[$];
    logic [dsp_pkg::INSTR_W-1:0] wr_dat[$];
    logic [dsp_pkg::INSTR_W-1:0] exp_adr[$];
    logic [dsp_pkg::INSTR_W-1:0] exp_dat[$];
    logic [dsp_pkg::PC_W-1:0]    bpc;             // Next program address to fill
    integer                      seed = 32'hefe9_a6e0;
    int                          errors = 0;
    int                          cycles = 0;
    int                          iwait = 0;
    int                          dwait = 0;

    dsp_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run reached %0d cycles before the tests finished", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // Slaves answer after 0 to 3 wait states
    always @(negedge clk) begin
        if (iwb_cyc && !iwb_ack) begin
            if (iwait == 0) begin
                iwb_ack   = 1'b1;
                iwb_dat_i = pmem[iwb_adr];
            end else begin
                iwait--;
            end
        end else begin
            iwb_ack = 1'b0;
            iwait   = $unsigned($random(seed)) % 4;
        end
        if (dwb_cyc && !dwb_ack) begin
            if (dwait == 0) begin
                dwb_ack   = 1'b1;
                dwb_dat_i = dmem[dwb_adr];
            end else begin
                dwait--;
            end
        end else begin
            dwb_ack = 1'b0;
            dwait   = $unsigned($random(seed)) % 4;
        end
    end

    // Bus monitor, fetch addresses and data writes
    always @(posedge clk) begin
        if (!rst && iwb_cyc && iwb_ack) begin
            fetch_q.push_back(iwb_adr);
        end
        if (!rst && dwb_cyc && dwb_ack && dwb_we) begin
            wr_adr.push_back(dwb_adr);
            wr_dat.push_back(dwb_dat_o);
            dmem[dwb_adr] = dwb_dat_o;
        end
    end

    task automatic check_addr(input string name, input logic [dsp_pkg::PC_W-1:0] got, exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [dsp_pkg::INSTR_W-1:0] got, exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_fault(input logic got, exp);
        if (got !== exp) begin
            $display("ERROR fault got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (4) @(posedge clk);
        fetch_q.delete();
        wr_adr.delete();
        wr_dat.delete();
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic begin_prog();
        bpc = '0;
        exp_fetch.delete();
        exp_adr.delete();
        exp_dat.delete();
        foreach (mregs[i]) begin
            mregs[i] = '0;
        end
    endtask

    task automatic emit(input logic [dsp_pkg::INSTR_W-1:0] word);
        pmem[bpc] = word;
        exp_fetch.push_back(bpc);
        bpc++;
    endtask

    task automatic emit_goto(input logic [dsp_pkg::PC_W-1:0] target);
        emit({4'b0000, target});
        bpc = target;
    endtask

    task automatic emit_short(input dsp_pkg::reg_sel_e r, input logic [8:0] imm);
        emit({4'b0001, r, imm});
        mregs[r] = {{7{imm[8]}}, imm};
    endtask

    task automatic emit_long(input dsp_pkg::reg_sel_e r, input logic [15:0] value);
        emit({5'b01010, 4'b0000, r, 4'b0000});
        emit(value);
        mregs[r] = value;
    endtask

    // Y=R when store is set, R=Y otherwise
    task automatic emit_xfer(input logic store, input dsp_pkg::reg_sel_e r,
                             input logic [1:0] p, input dsp_pkg::post_mod_e pm);
        logic [15:0] adr;
        adr = mregs[p];
        emit({store ? 5'b01100 : 5'b01111, 4'b0000, r, p, pm});
        if (store) begin
            exp_adr.push_back(adr);
            exp_dat.push_back(mregs[r]);
        end
        case (pm)
            dsp_pkg::PM_INC:  mregs[p] = adr + 16'd1;
            dsp_pkg::PM_DEC:  mregs[p] = adr - 16'd1;
            dsp_pkg::PM_STEP: mregs[p] = adr + mregs[4];
            default:          mregs[p] = adr;
        endcase
        if (!store) begin
            mregs[r] = dmem[adr];  // Load wins over the pointer update
        end
    endtask

    task automatic run_prog();
        logic [dsp_pkg::PC_W-1:0] halt;
        halt = bpc;
        emit_goto(halt);
        exp_fetch.push_back(halt);  // Self loop
        apply_reset();
        while (fetch_q.size() < exp_fetch.size()) begin
            @(posedge clk);
        end
        foreach (exp_fetch[i]) begin
            check_addr("iwb_adr", fetch_q[i], exp_fetch[i]);
        end
        if (wr_adr.size() != exp_adr.size()) begin
            $display("Data bus made %0d writes, %0d expected", wr_adr.size(), exp_adr.size());
            errors++;
        end else begin
            foreach (exp_adr[i]) begin
                check_word("dwb_adr", wr_adr[i], exp_adr[i]);
                check_word("dwb_dat_o", wr_dat[i], exp_dat[i]);
            end
        end
    endtask

    task automatic test_sequential();
        begin_prog();
        for (int i = 0; i < 6; i++) begin
            emit_short(dsp_pkg::R0, 9'(i * 3));
        end
        run_prog();
        check_fault(fault, 1'b0);
    endtask

    task automatic test_goto();
        begin_prog();
        emit_short(dsp_pkg::R1, 9'h005);
        emit_goto(12'h0a0);
        emit_short(dsp_pkg::R2, 9'h001);
        emit_goto(12'hff3);         // Target with bit 11 set
        emit_short(dsp_pkg::R3, 9'h002);
        run_prog();
        check_fault(fault, 1'b0);
    endtask

    task automatic test_imm_loads();
        begin_prog();
        emit_short(dsp_pkg::R0, 9'h020);
        emit_short(dsp_pkg::R1, 9'h1fb);
        emit_xfer(1'b1, dsp_pkg::R1, 2'd0, dsp_pkg::PM_INC);
        emit_short(dsp_pkg::RJ, 9'h0ff);
        emit_xfer(1'b1, dsp_pkg::RJ, 2'd0, dsp_pkg::PM_INC);
        emit_long(dsp_pkg::R2, 16'hbeef);
        emit_xfer(1'b1, dsp_pkg::R2, 2'd0, dsp_pkg::PM_INC);
        emit_long(dsp_pkg::RJ, 16'h8001);
        emit_xfer(1'b1, dsp_pkg::RJ, 2'd0, dsp_pkg::PM_INC);
        emit_short(dsp_pkg::R3, 9'h100);
        emit_xfer(1'b1, dsp_pkg::R3, 2'd0, dsp_pkg::PM_INC);
        emit_long(dsp_pkg::R0, 16'h0300);
        emit_xfer(1'b1, dsp_pkg::R0, 2'd0, dsp_pkg::PM_NONE);
        run_prog();
    endtask

    task automatic test_post_mod();
        dsp_pkg::post_mod_e modes [8];
        modes = '{dsp_pkg::PM_INC, dsp_pkg::PM_INC, dsp_pkg::PM_DEC, dsp_pkg::PM_STEP,
                  dsp_pkg::PM_NONE, dsp_pkg::PM_STEP, dsp_pkg::PM_DEC, dsp_pkg::PM_NONE};
        begin_prog();
        emit_short(dsp_pkg::R1, 9'h040);
        emit_long(dsp_pkg::RJ, 16'h0007);
        emit_long(dsp_pkg::R0, 16'h5a5a);
        foreach (modes[i]) begin
            emit_xfer(1'b1, dsp_pkg::R0, 2'd1, modes[i]);
        end
        emit_short(dsp_pkg::RJ, 9'h1fe);   // Negative step
        emit_xfer(1'b1, dsp_pkg::R0, 2'd1, dsp_pkg::PM_STEP);
        emit_xfer(1'b1, dsp_pkg::R1, 2'd1, dsp_pkg::PM_STEP);
        run_prog();
    endtask

    task automatic test_ram_load();
        dmem[16'h0480] = $random(seed);
        begin_prog();
        emit_long(dsp_pkg::R3, 16'h0480);
        emit_xfer(1'b0, dsp_pkg::R2, 2'd3, dsp_pkg::PM_INC);
        emit_short(dsp_pkg::R0, 9'h090);
        emit_xfer(1'b1, dsp_pkg::R2, 2'd0, dsp_pkg::PM_INC);
        emit_xfer(1'b1, dsp_pkg::R3, 2'd0, dsp_pkg::PM_NONE);
        run_prog();
    endtask

    task automatic test_fault();
        begin_prog();
        emit_short(dsp_pkg::R0, 9'h001);
        emit(16'hf800);                    // T = 11111, undefined
        emit_short(dsp_pkg::R1, 9'h002);
        run_prog();
        check_fault(fault, 1'b1);
        apply_reset();
        check_fault(fault, 1'b0);
    endtask

    initial begin
        rst       = 1'b0;
        iwb_ack   = 1'b0;
        iwb_dat_i = '0;
        dwb_ack   = 1'b0;
        dwb_dat_i = '0;
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = {a[7:0], a[15:8]} ^ 16'h3c5a;
        end
        #1 rst = 1'b1;
        test_sequential();
        test_goto();
        test_imm_loads();
        test_post_mod();
        test_ram_load();
        test_fault();
        $display("Checks finished with %0d errors and %0d assertion failures",
                 errors, dut0.sva0.fail_count);
        if (errors == 0 && dut0.sva0.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verif/dsp_tb_sva.sv
// Wishbone protocol assertions for both buses of the DSP front end, bound into the top level
`timescale 1ns/1ps

module dsp_tb_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        iwb_cyc,
    input logic                        iwb_stb,
    input logic                        iwb_ack,
    input logic [dsp_pkg::PC_W-1:0]    iwb_adr,
    input logic                        dwb_cyc,
    input logic                        dwb_stb,
    input logic                        dwb_ack,
    input logic [dsp_pkg::INSTR_W-1:0] dwb_adr
);

    int fail_count = 0;  // Failed assertion attempts

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        iwb_stb == iwb_cyc && dwb_stb == dwb_cyc)
        else begin
            $error("stb differs from cyc");
            fail_count++;
        end

    // Address held through wait states
    a_iadr_stable: assert property (@(posedge clk) disable iff (rst)
        iwb_cyc && !iwb_ack |=> $stable(iwb_adr))
        else begin
            $error("iwb_adr changed during a cycle");
            fail_count++;
        end

    a_dadr_stable: assert property (@(posedge clk) disable iff (rst)
        dwb_cyc && !dwb_ack |=> $stable(dwb_adr))
        else begin
            $error("dwb_adr changed during a cycle");
            fail_count++;
        end

    a_one_bus: assert property (@(posedge clk) disable iff (rst) !(iwb_cyc && dwb_cyc))
        else begin
            $error("both buses active");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge clk) rst |-> !iwb_cyc)
        else begin
            $error("iwb_cyc high in reset");
            fail_count++;
        end

endmodule

bind dsp_top dsp_tb_sva sva0 (
    .clk     (clk),
    .rst     (rst),
    .iwb_cyc (iwb_cyc),
    .iwb_stb (iwb_stb),
    .iwb_ack (iwb_ack),
    .iwb_adr (iwb_adr),
    .dwb_cyc (dwb_cyc),
    .dwb_stb (dwb_stb),
    .dwb_ack (dwb_ack),
    .dwb_adr (dwb_adr)
);

//--- vlog.f
rtl/dsp_pkg.sv
rtl/dsp_ctrl_if.sv
rtl/dsp_ctrl.sv
rtl/dsp_xaau.sv
rtl/dsp_yaau.sv
rtl/dsp_top.sv
verif/dsp_tb_sva.sv
verif/dsp_tb.sv
